/* mem_subsystem_top.f */
verilog/mem_pkg.sv
verilog/store_align.sv
verilog/data_ram.sv
verilog/ex_mem_stage.sv
verilog/mem_wb_stage.sv
verilog/mem_subsystem_top.sv
verification/mem_subsystem_checker.sv
verification/mem_subsystem_tb.sv

/* Bender.yml */
package:
  name: mem_subsystem

sources:
  - files:
      - verilog/mem_pkg.sv
      - verilog/store_align.sv
      - verilog/data_ram.sv
      - verilog/ex_mem_stage.sv
      - verilog/mem_wb_stage.sv
      - verilog/mem_subsystem_top.sv
  - target: test
    files:
      - verification/mem_subsystem_checker.sv
      - verification/mem_subsystem_tb.sv

/* verification/mem_subsystem_tb.sv */
module mem_subsystem_tb;

    typedef struct packed {
        mem_pkg::ex_item_t              item;
        logic                           flush;
        logic                           hold;
        logic [mem_pkg::DATA_WIDTH-1:0] exp_data;
    } stim_row_t;

    logic                           clk;
    logic                           rst_n;
    logic                           flush_i;
    logic                           hold_i;
    logic                           ex_valid_i;
    logic                           ex_ready_go_i;
    logic                           allow_in_o;
    logic                           retire_ready_i;
    logic                           wb_valid_o;
    mem_pkg::ex_item_t              ex_item_i;
    mem_pkg::wb_item_t              wb_item_o;
    logic [mem_pkg::DATA_WIDTH-1:0] row_exp;
    stim_row_t                      stim_table [24];
    int                             row_count;
    integer                         seed = 32'hce9a;
    int                             mismatch_count;
    int                             error_count;
    int                             pending;
    int                             retired;

    mem_subsystem_top mem_subsystem_top_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .flush_i        (flush_i),
        .hold_i         (hold_i),
        .ex_item_i      (ex_item_i),
        .ex_valid_i     (ex_valid_i),
        .ex_ready_go_i  (ex_ready_go_i),
        .allow_in_o     (allow_in_o),
        .retire_ready_i (retire_ready_i),
        .wb_valid_o     (wb_valid_o),
        .wb_item_o      (wb_item_o)
    );

    mem_subsystem_checker checker_inst (
        .clk              (clk),
        .rst_n            (rst_n),
        .flush_i          (flush_i),
        .ex_item_i        (ex_item_i),
        .ex_valid_i       (ex_valid_i),
        .ex_ready_go_i    (ex_ready_go_i),
        .allow_in_i       (allow_in_o),
        .retire_ready_i   (retire_ready_i),
        .wb_valid_i       (wb_valid_o),
        .wb_item_i        (wb_item_o),
        .row_exp_i        (row_exp),
        .mismatch_count_o (mismatch_count),
        .error_count_o    (error_count),
        .pending_o        (pending),
        .retired_o        (retired)
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic add_row(input logic [3:0] ctrl, input logic [31:0] alu, input logic [31:0] sdata,
                           input logic [4:0] rd, input logic [2:0] f3, input logic flush,
                           input logic hold, input logic [31:0] exp_data);
        stim_table[row_count] = '{'{alu, sdata, ctrl, rd, f3}, flush, hold, exp_data};
        row_count = row_count + 1;
    endtask

    task automatic fill_table();
        logic [mem_pkg::CTRL_WIDTH-1:0] ld;
        logic [mem_pkg::CTRL_WIDTH-1:0] st;
        logic [mem_pkg::CTRL_WIDTH-1:0] alu;
        ld                    = '0;
        st                    = '0;
        alu                   = '0;
        ld[mem_pkg::CF_READ]  = 1'b1;
        ld[1:0]               = mem_pkg::WB_MEM;
        st[mem_pkg::CF_WRITE] = 1'b1;
        alu[1:0]              = mem_pkg::WB_ALU;
        // word round trip and an ALU result
        add_row(st,  32'h100, 32'h1234_5678, 5'd0, mem_pkg::F3_W, 1'b0, 1'b0, 32'h0);
        add_row(ld,  32'h100, 32'h0, 5'd1, mem_pkg::F3_W, 1'b0, 1'b0, 32'h1234_5678);
        add_row(alu, 32'hdead_beef, 32'h0, 5'd2, mem_pkg::F3_W, 1'b0, 1'b0, 32'hdead_beef);
        // one byte into each lane, back to back
        add_row(st,  32'h104, 32'h0, 5'd0, mem_pkg::F3_W, 1'b0, 1'b0, 32'h0);
        add_row(st,  32'h104, 32'hffff_ff81, 5'd0, mem_pkg::F3_B, 1'b0, 1'b0, 32'h0);
        add_row(st,  32'h105, 32'h0000_007f, 5'd0, mem_pkg::F3_B, 1'b0, 1'b0, 32'h0);
        add_row(st,  32'h106, 32'h0000_00c3, 5'd0, mem_pkg::F3_B, 1'b0, 1'b0, 32'h0);
        add_row(st,  32'h107, 32'h0000_0005, 5'd0, mem_pkg::F3_B, 1'b0, 1'b0, 32'h0);
        add_row(ld,  32'h104, 32'h0, 5'd3, mem_pkg::F3_B,  1'b0, 1'b1, 32'hffff_ff81);
        add_row(ld,  32'h104, 32'h0, 5'd4, mem_pkg::F3_BU, 1'b0, 1'b0, 32'h0000_0081);
        add_row(ld,  32'h105, 32'h0, 5'd5, mem_pkg::F3_B,  1'b0, 1'b0, 32'h0000_007f);
        add_row(ld,  32'h106, 32'h0, 5'd6, mem_pkg::F3_BU, 1'b0, 1'b0, 32'h0000_00c3);
        add_row(ld,  32'h106, 32'h0, 5'd7, mem_pkg::F3_B,  1'b0, 1'b0, 32'hffff_ffc3);
        add_row(ld,  32'h107, 32'h0, 5'd8, mem_pkg::F3_B,  1'b0, 1'b0, 32'h0000_0005);
        // halves into both halves of one word
        add_row(st,  32'h108, 32'h1122_3344, 5'd0, mem_pkg::F3_W, 1'b0, 1'b0, 32'h0);
        add_row(st,  32'h108, 32'hcafe_a5f0, 5'd0, mem_pkg::F3_H, 1'b0, 1'b0, 32'h0);
        add_row(st,  32'h10a, 32'h0000_8001, 5'd0, mem_pkg::F3_H, 1'b0, 1'b0, 32'h0);
        add_row(ld,  32'h108, 32'h0, 5'd9,  mem_pkg::F3_H,  1'b0, 1'b1, 32'hffff_a5f0);
        add_row(ld,  32'h10a, 32'h0, 5'd10, mem_pkg::F3_HU, 1'b0, 1'b0, 32'h0000_8001);
        add_row(ld,  32'h10a, 32'h0, 5'd11, mem_pkg::F3_H,  1'b0, 1'b0, 32'hffff_8001);
        // killed store must leave the word alone
        add_row(st,  32'h100, 32'hbadc_0ffe, 5'd0, mem_pkg::F3_W, 1'b1, 1'b0, 32'h0);
        add_row(ld,  32'h100, 32'h0, 5'd12, mem_pkg::F3_W, 1'b0, 1'b1, 32'h1234_5678);
        add_row(alu, 32'h0000_0042, 32'h0, 5'd13, mem_pkg::F3_W, 1'b1, 1'b0, 32'h0000_0042);
        add_row(ld,  32'h108, 32'h0, 5'd14, mem_pkg::F3_HU, 1'b0, 1'b0, 32'h0000_a5f0);
    endtask

    task automatic report_and_finish(input logic timed_out);
        int other;
        other = error_count + (timed_out ? 1 : 0);
        $display("retired %0d, mismatches %0d, other errors %0d", retired, mismatch_count, other);
        if (mismatch_count == 0 && other == 0)
        begin
            $display("all tests passed");
        end
        else
        begin
            $display("tests failed");
        end
        $finish;
    endtask

    initial
    begin
        int   stall;
        logic taken;
        rst_n         = 1'b0;
        flush_i       = 1'b0;
        hold_i        = 1'b0;
        ex_valid_i    = 1'b0;
        ex_ready_go_i = 1'b1;
        ex_item_i     = '0;
        row_exp       = '0;
        fill_table();
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        foreach (stim_table[i])
        begin
            @(posedge clk);
            ex_item_i     <= stim_table[i].item;
            ex_valid_i    <= 1'b1;
            // every fourth entry is not ready in execute for its first cycle
            ex_ready_go_i <= ((i % 4) != 3);
            flush_i       <= stim_table[i].flush;
            hold_i        <= stim_table[i].hold;
            row_exp       <= stim_table[i].exp_data;
            stall = 0;
            taken = 1'b0;
            // entry stays on the bus until the stage takes it
            while (!taken)
            begin
                @(negedge clk);
                if (allow_in_o && ex_ready_go_i)
                begin
                    taken = 1'b1;
                end
                else
                begin
                    @(posedge clk);
                    ex_ready_go_i <= 1'b1;
                    stall = stall + 1;
                    // hold lasts three stalled cycles, then the stage may drain
                    if (stall >= 3)
                        hold_i <= 1'b0;
                end
            end
        end
        @(posedge clk);
        ex_valid_i <= 1'b0;
        flush_i    <= 1'b0;
        hold_i     <= 1'b0;
        while (pending != 0)
            @(posedge clk);
        // idle time to catch any extra retire
        repeat (10) @(posedge clk);
        report_and_finish(1'b0);
    end

    // writeback accepts about three cycles in four
    initial
    begin
        retire_ready_i = 1'b0;
        forever
        begin
            @(posedge clk);
            retire_ready_i <= (($random(seed) & 3) != 0);
        end
    end

    // 40 cycles per table entry
    initial
    begin
        repeat ($size(stim_table) * 40) @(posedge clk);
        $display("timeout: %0d retires still outstanding when the cycle limit ran out", pending);
        report_and_finish(1'b1);
    end

endmodule

/* verification/mem_subsystem_checker.sv */
module mem_subsystem_checker (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            flush_i,
    input  mem_pkg::ex_item_t               ex_item_i,
    input  logic                            ex_valid_i,
    input  logic                            ex_ready_go_i,
    input  logic                            allow_in_i,
    input  logic                            retire_ready_i,
    input  logic                            wb_valid_i,
    input  mem_pkg::wb_item_t               wb_item_i,
    input  logic [mem_pkg::DATA_WIDTH-1:0]  row_exp_i,
    output int                              mismatch_count_o,
    output int                              error_count_o,
    output int                              pending_o,
    output int                              retired_o
);

    mem_pkg::wb_item_t              expect_q [$];
    logic [mem_pkg::DATA_WIDTH-1:0] shadow [mem_pkg::RAM_DEPTH];

    // pick the addressed byte or half and extend it
    function automatic logic [31:0] extend_load(input logic [31:0] word, input logic [1:0] lo,
                                                input logic [2:0] f3);
        logic [7:0]  b;
        logic [15:0] h;
        b = 8'(word >> (8 * lo));
        h = 16'(word >> (lo[1] ? 16 : 0));
        case (f3)
            mem_pkg::F3_B:  return {{24{b[7]}}, b};
            mem_pkg::F3_BU: return {24'd0, b};
            mem_pkg::F3_H:  return {{16{h[15]}}, h};
            mem_pkg::F3_HU: return {16'd0, h};
            default:        return word;
        endcase
    endfunction

    task automatic apply_store(input mem_pkg::ex_item_t it);
        logic [mem_pkg::WORD_ADDR_WIDTH-1:0] idx;
        logic [1:0]                          lo;
        idx = it.alu_result[mem_pkg::ADDR_WIDTH-1:2];
        lo  = it.alu_result[1:0];
        case (it.func3)
            mem_pkg::F3_B: shadow[idx][8*lo +: 8] = it.store_data[7:0];
            mem_pkg::F3_H: shadow[idx][16*lo[1] +: 16] = it.store_data[15:0];
            default:       shadow[idx] = it.store_data;
        endcase
    endtask

    // shadow memory is updated in acceptance order, which is program order
    task automatic take_item(input mem_pkg::ex_item_t it, input logic [31:0] table_exp);
        mem_pkg::wb_item_t want;
        logic [1:0]        wb_sel;
        wb_sel = it.ctrl[1:0];
        if (it.ctrl[mem_pkg::CF_WRITE])
            apply_store(it);
        want.rd    = it.rd;
        want.wb_en = (wb_sel != mem_pkg::WB_NONE);
        if (wb_sel == mem_pkg::WB_MEM)
            want.data = extend_load(shadow[it.alu_result[mem_pkg::ADDR_WIDTH-1:2]],
                                    it.alu_result[1:0], it.func3);
        else
            want.data = it.alu_result;
        if (want.wb_en && table_exp !== want.data)
        begin
            $display("mismatch table entry for rd %0d: table %h, model %h",
                     it.rd, table_exp, want.data);
            mismatch_count_o = mismatch_count_o + 1;
        end
        expect_q.push_back(want);
    endtask

    task automatic check_retire(input mem_pkg::wb_item_t got);
        mem_pkg::wb_item_t want;
        if (expect_q.size() == 0)
        begin
            $display("unexpected retire of rd %0d with no item outstanding", got.rd);
            error_count_o = error_count_o + 1;
        end
        else
        begin
            want      = expect_q.pop_front();
            retired_o = retired_o + 1;
            if (got.rd !== want.rd)
            begin
                $display("mismatch wb_item_o.rd: expected %h, got %h", want.rd, got.rd);
                mismatch_count_o = mismatch_count_o + 1;
            end
            if (got.wb_en !== want.wb_en)
            begin
                $display("mismatch wb_item_o.wb_en: expected %h, got %h", want.wb_en, got.wb_en);
                mismatch_count_o = mismatch_count_o + 1;
            end
            if (want.wb_en && got.data !== want.data)
            begin
                $display("mismatch wb_item_o.data: expected %h, got %h", want.data, got.data);
                mismatch_count_o = mismatch_count_o + 1;
            end
        end
    endtask

    initial
    begin
        @(posedge rst_n);
        @(negedge clk);
        if (wb_valid_i !== 1'b0)
        begin
            $display("mismatch wb_valid_o after reset: expected 0, got %h", wb_valid_i);
            mismatch_count_o = mismatch_count_o + 1;
        end
        if (allow_in_i !== 1'b1)
        begin
            $display("mismatch allow_in_o after reset: expected 1, got %h", allow_in_i);
            mismatch_count_o = mismatch_count_o + 1;
        end
    end

    // inputs settle mid-cycle, both events happen at the next rising edge
    always @(negedge clk)
    begin
        if (rst_n)
        begin
            if (ex_valid_i && ex_ready_go_i && allow_in_i && !flush_i)
                take_item(ex_item_i, row_exp_i);
            if (wb_valid_i && retire_ready_i)
                check_retire(wb_item_i);
            pending_o = expect_q.size();
        end
    end

endmodule

/* verilog/mem_subsystem_top.sv */
module mem_subsystem_top (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               flush_i,
    input  logic               hold_i,
    input  mem_pkg::ex_item_t  ex_item_i,
    input  logic               ex_valid_i,
    input  logic               ex_ready_go_i,
    output logic               allow_in_o,
    input  logic               retire_ready_i,
    output logic               wb_valid_o,
    output mem_pkg::wb_item_t  wb_item_o
);

    logic                           ram_req;
    mem_pkg::ram_req_t              ram_req_item;
    logic                           ram_addr_ok;
    logic [mem_pkg::DATA_WIDTH-1:0] ram_rdata;
    logic                           allow_in_wb;
    logic                           mem_valid;
    logic                           mem_ready_go;
    mem_pkg::mem_item_t             mem_item;

    ex_mem_stage ex_mem_stage_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .flush_i        (flush_i),
        .hold_i         (hold_i),
        .ex_item_i      (ex_item_i),
        .ex_valid_i     (ex_valid_i),
        .ex_ready_go_i  (ex_ready_go_i),
        .allow_in_o     (allow_in_o),
        .ram_addr_ok_i  (ram_addr_ok),
        .ram_req_o      (ram_req),
        .ram_req_o_item (ram_req_item),
        .allow_in_wb_i  (allow_in_wb),
        .mem_valid_o    (mem_valid),
        .mem_ready_go_o (mem_ready_go),
        .mem_item_o     (mem_item)
    );

    data_ram data_ram_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .req_i      (ram_req),
        .req_item_i (ram_req_item),
        .addr_ok_o  (ram_addr_ok),
        .rdata_o    (ram_rdata)
    );

    mem_wb_stage mem_wb_stage_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .mem_valid_i    (mem_valid),
        .mem_ready_go_i (mem_ready_go),
        .mem_item_i     (mem_item),
        .ram_rdata_i    (ram_rdata),
        .allow_in_o     (allow_in_wb),
        .retire_ready_i (retire_ready_i),
        .wb_valid_o     (wb_valid_o),
        .wb_item_o      (wb_item_o)
    );

endmodule

/* verilog/mem_wb_stage.sv */
module mem_wb_stage (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            mem_valid_i,
    input  logic                            mem_ready_go_i,
    input  mem_pkg::mem_item_t              mem_item_i,
    input  logic [mem_pkg::DATA_WIDTH-1:0]  ram_rdata_i,
    output logic                            allow_in_o,
    input  logic                            retire_ready_i,
    output logic                            wb_valid_o,
    output mem_pkg::wb_item_t               wb_item_o
);

    logic                              valid_q;
    logic                              take;
    logic [mem_pkg::RD_WIDTH-1:0]      rd_q;
    logic [mem_pkg::WB_SEL_WIDTH-1:0]  wb_sel_q;
    logic [mem_pkg::F3_WIDTH-1:0]      func3_q;
    logic [1:0]                        addr_lo_q;
    logic [mem_pkg::DATA_WIDTH-1:0]    alu_result_q;
    logic [7:0]                        load_byte;
    logic [15:0]                       load_half;
    logic [mem_pkg::DATA_WIDTH-1:0]    load_data;

    // empty or retiring this cycle
    assign allow_in_o = ~valid_q | retire_ready_i;
    assign take       = mem_valid_i & mem_ready_go_i & allow_in_o;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            valid_q <= 1'b0;
        end
        else if (allow_in_o)
        begin
            valid_q <= mem_valid_i & mem_ready_go_i;
        end
    end

    // store data is not needed past the RAM
    always_ff @(posedge clk)
    begin
        if (take)
        begin
            rd_q         <= mem_item_i.rd;
            wb_sel_q     <= mem_item_i.ctrl[mem_pkg::WB_SEL_WIDTH-1:0];
            func3_q      <= mem_item_i.func3;
            addr_lo_q    <= mem_item_i.alu_result[1:0];
            alu_result_q <= mem_item_i.alu_result;
        end
    end

    // rdata is held by the RAM while this item waits
    assign load_byte = ram_rdata_i[8*addr_lo_q +: 8];
    assign load_half = ram_rdata_i[16*addr_lo_q[1] +: 16];

    always_comb
    begin
        case (func3_q)
            mem_pkg::F3_B:
            begin
                load_data = {{24{load_byte[7]}}, load_byte};
            end
            mem_pkg::F3_H:
            begin
                load_data = {{16{load_half[15]}}, load_half};
            end
            mem_pkg::F3_BU:
            begin
                load_data = {24'd0, load_byte};
            end
            mem_pkg::F3_HU:
            begin
                load_data = {16'd0, load_half};
            end
            default:
            begin
                load_data = ram_rdata_i;
            end
        endcase
    end

    assign wb_valid_o      = valid_q;
    assign wb_item_o.rd    = rd_q;
    assign wb_item_o.wb_en = (wb_sel_q != mem_pkg::WB_NONE);
    // anything other than a load writes the ALU result
    assign wb_item_o.data  = (wb_sel_q == mem_pkg::WB_MEM) ? load_data : alu_result_q;

endmodule

/* verilog/ex_mem_stage.sv */
module ex_mem_stage (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               flush_i,
    input  logic               hold_i,
    input  mem_pkg::ex_item_t  ex_item_i,
    input  logic               ex_valid_i,
    input  logic               ex_ready_go_i,
    output logic               allow_in_o,
    input  logic               ram_addr_ok_i,
    output logic               ram_req_o,
    output mem_pkg::ram_req_t  ram_req_o_item,
    input  logic               allow_in_wb_i,
    output logic               mem_valid_o,
    output logic               mem_ready_go_o,
    output mem_pkg::mem_item_t mem_item_o
);

    mem_pkg::mem_item_t item_q;
    logic               valid_q;
    logic               pipe_valid;
    logic               mem_read;
    logic               mem_write;
    logic               req_type;
    logic [mem_pkg::STRB_WIDTH-1:0] wstrb;
    logic [mem_pkg::DATA_WIDTH-1:0] wdata;

    // incoming item survives only without flush
    assign pipe_valid = ex_valid_i & ex_ready_go_i & ~flush_i;

    // access type only counts with a live item
    assign mem_read  = item_q.ctrl[mem_pkg::CF_READ] & valid_q;
    assign mem_write = item_q.ctrl[mem_pkg::CF_WRITE] & valid_q;
    assign req_type  = mem_read | mem_write;

    // no request while writeback is full, so load data is never dropped
    assign ram_req_o = allow_in_wb_i & ~hold_i & req_type;

    assign mem_ready_go_o = ((ram_req_o & ram_addr_ok_i) | ~req_type) & ~hold_i;
    assign allow_in_o     = ~valid_q | (mem_ready_go_o & allow_in_wb_i);
    assign mem_valid_o    = valid_q;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            valid_q <= 1'b0;
        end
        else if (allow_in_o)
        begin
            valid_q <= pipe_valid;
        end
    end

    always_ff @(posedge clk)
    begin
        if (pipe_valid & allow_in_o)
        begin
            item_q <= ex_item_i;
        end
    end

    store_align store_align_inst (
        .addr_lo_i    (item_q.alu_result[1:0]),
        .func3_i      (item_q.func3),
        .store_data_i (item_q.store_data),
        .wstrb_o      (wstrb),
        .wdata_o      (wdata)
    );

    // address is the low part of the ALU result
    assign ram_req_o_item.addr  = item_q.alu_result[mem_pkg::ADDR_WIDTH-1:0];
    assign ram_req_o_item.wdata = wdata;
    assign ram_req_o_item.wstrb = wstrb;
    assign ram_req_o_item.we    = mem_write;

    assign mem_item_o = item_q;

endmodule

/* verilog/data_ram.sv */
module data_ram (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            req_i,
    input  mem_pkg::ram_req_t               req_item_i,
    output logic                            addr_ok_o,
    output logic [mem_pkg::DATA_WIDTH-1:0]  rdata_o
);

    logic [mem_pkg::DATA_WIDTH-1:0]      mem_q [mem_pkg::RAM_DEPTH];
    logic [mem_pkg::DATA_WIDTH-1:0]      rdata_q;
    logic [mem_pkg::WORD_ADDR_WIDTH-1:0] word_addr;
    logic                                commit_q;
    logic                                accept;
    logic                                accept_wr;
    logic                                accept_rd;

    assign word_addr = req_item_i.addr[mem_pkg::ADDR_WIDTH-1:2];

    // busy for one cycle while a write commits
    assign addr_ok_o = ~commit_q;

    assign accept    = req_i & addr_ok_o;
    assign accept_wr = accept & req_item_i.we;
    assign accept_rd = accept & ~req_item_i.we;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            commit_q <= 1'b0;
        end
        else
        begin
            commit_q <= accept_wr;
        end
    end

    // only strobed byte lanes are written
    always_ff @(posedge clk)
    begin
        if (accept_wr)
        begin
            for (int b = 0; b < mem_pkg::STRB_WIDTH; b++)
            begin
                if (req_item_i.wstrb[b])
                begin
                    mem_q[word_addr][8*b +: 8] <= req_item_i.wdata[8*b +: 8];
                end
            end
        end
    end

    // read data stays put until the next accepted read
    always_ff @(posedge clk)
    begin
        if (accept_rd)
        begin
            rdata_q <= mem_q[word_addr];
        end
    end

    assign rdata_o = rdata_q;

endmodule

/* verilog/store_align.sv */
module store_align (
    input  logic [1:0]                      addr_lo_i,
    input  logic [mem_pkg::F3_WIDTH-1:0]    func3_i,
    input  logic [mem_pkg::DATA_WIDTH-1:0]  store_data_i,
    output logic [mem_pkg::STRB_WIDTH-1:0]  wstrb_o,
    output logic [mem_pkg::DATA_WIDTH-1:0]  wdata_o
);

    // replicate the low part across all lanes, strobes pick the lane
    always_comb
    begin
        case (func3_i)
            mem_pkg::F3_B:
            begin
                wdata_o = {4{store_data_i[7:0]}};
                wstrb_o = 4'b0001 << addr_lo_i;
            end
            mem_pkg::F3_H:
            begin
                wdata_o = {2{store_data_i[15:0]}};
                // only bit 1 matters, halves are aligned
                if (addr_lo_i[1])
                begin
                    wstrb_o = 4'b1100;
                end
                else
                begin
                    wstrb_o = 4'b0011;
                end
            end
            default:
            begin
                // word store
                wdata_o = store_data_i;
                wstrb_o = 4'b1111;
            end
        endcase
    end

endmodule

/* verilog/mem_pkg.sv */
package mem_pkg;

    // datapath widths
    localparam int DATA_WIDTH      = 32;
    localparam int ADDR_WIDTH      = 12;
    localparam int RD_WIDTH        = 5;
    localparam int CTRL_WIDTH      = 4;
    localparam int F3_WIDTH        = 3;
    localparam int WB_SEL_WIDTH    = 2;
    localparam int STRB_WIDTH      = DATA_WIDTH / 8;

    // byte address splits into word index and two lane bits
    localparam int WORD_ADDR_WIDTH = ADDR_WIDTH - 2;
    localparam int RAM_DEPTH       = 1 << WORD_ADDR_WIDTH;

    // control nibble holds read, write and writeback select
    localparam int CF_READ  = 3;
    localparam int CF_WRITE = 2;

    localparam logic [WB_SEL_WIDTH-1:0] WB_NONE = 2'd0;
    localparam logic [WB_SEL_WIDTH-1:0] WB_ALU  = 2'd1;
    localparam logic [WB_SEL_WIDTH-1:0] WB_MEM  = 2'd2;

    // load/store width encodings
    localparam logic [F3_WIDTH-1:0] F3_B  = 3'd0;
    localparam logic [F3_WIDTH-1:0] F3_H  = 3'd1;
    localparam logic [F3_WIDTH-1:0] F3_W  = 3'd2;
    localparam logic [F3_WIDTH-1:0] F3_BU = 3'd4;
    localparam logic [F3_WIDTH-1:0] F3_HU = 3'd5;

    // item handed over by execute, 76 bits
    typedef struct packed {
        logic [DATA_WIDTH-1:0] alu_result;
        logic [DATA_WIDTH-1:0] store_data;
        logic [CTRL_WIDTH-1:0] ctrl;
        logic [RD_WIDTH-1:0]   rd;
        logic [F3_WIDTH-1:0]   func3;
    } ex_item_t;

    // memory stage keeps the same layout
    typedef ex_item_t mem_item_t;

    typedef struct packed {
        logic [ADDR_WIDTH-1:0] addr;
        logic [DATA_WIDTH-1:0] wdata;
        logic [STRB_WIDTH-1:0] wstrb;
        logic                  we;
    } ram_req_t;

    typedef struct packed {
        logic [RD_WIDTH-1:0]   rd;
        logic                  wb_en;
        logic [DATA_WIDTH-1:0] data;
    } wb_item_t;

endpackage
